// ==== logic/script_pkg.sv ====
package script_pkg;

	// script storage depth in words
	localparam int script_words = 256;

	// synchronizer depth between clk_a and clk_b
	localparam int cdc_stages = 4;

	typedef logic [9:0] host_addr_t;
	typedef logic [7:0] word_addr_t;
	typedef logic [31:0] script_word_t;
	typedef logic [15:0] pin_word_t;
	typedef logic [23:0] wait_count_t;

	// host request bundle is wdata, addr, we, req
	localparam int req_bus_width = $bits(script_word_t) + $bits(host_addr_t) + 2;

	// response bundle is read word and ack
	localparam int rsp_bus_width = $bits(script_word_t) + 1;

	// opcode in bits 31:28, anything else runs as a no-op
	typedef enum logic [3:0] {
		op_end = 4'h0,
		op_set = 4'h1,
		op_wait = 4'h2,
		op_jump = 4'h3
	} opcode_t;

	typedef enum logic [1:0] {
		exec_idle,
		exec_run,
		exec_wait
	} exec_state_t;

endpackage

// ==== logic/bus_cdc.sv ====
`timescale 1ns/10ps

module bus_cdc
	import script_pkg::*;
#(
	parameter int data_width = 1
) (
	input logic clk_dst,
	input logic rst_n,
	input logic [data_width-1:0] data_in,
	output logic [data_width-1:0] data_out
);

	// only for bundles held stable over a whole handshake
	logic [data_width-1:0] stage_q [cdc_stages];

	always_ff @(posedge clk_dst) begin
		if (!rst_n) begin
			for (int i = 0; i < cdc_stages; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= data_in;
			for (int i = 1; i < cdc_stages; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign data_out = stage_q[cdc_stages-1];

endmodule

// ==== logic/instr_if.sv ====
`timescale 1ns/10ps

interface instr_if
	import script_pkg::*;
();

	// fetch to exec
	logic valid;
	script_word_t instr;
	word_addr_t pc;

	// exec back to fetch
	logic advance;
	logic redirect;
	word_addr_t target;

	modport fetch (
		output valid, instr, pc,
		input advance, redirect, target
	);

	modport exec (
		input valid, instr,
		output advance, redirect, target
	);

endinterface

// ==== logic/script_mem.sv ====
`timescale 1ns/10ps

module script_mem
	import script_pkg::*;
(
	input logic clk_a,
	input logic clk_b,
	input logic rst_n,
	input host_addr_t host_addr,
	input script_word_t host_wdata,
	input logic host_we,
	input logic host_req,
	output script_word_t host_rdata,
	output logic host_ack,
	input word_addr_t rd_addr,
	output script_word_t rd_data
);

	// clk_b side copies of the host request
	script_word_t wdata_s;
	host_addr_t addr_s;
	logic we_s;
	logic req_s;

	logic ack_b;
	logic we_pulse;
	script_word_t host_q;
	word_addr_t host_word;

	// reset as seen in clk_a
	logic [cdc_stages-1:0] rst_a_q;
	logic rst_a_n;

	script_word_t mem_q [script_words];

	always_ff @(posedge clk_a) begin
		rst_a_q <= {rst_a_q[cdc_stages-2:0], rst_n};
	end

	assign rst_a_n = rst_a_q[cdc_stages-1];

	bus_cdc #(
		.data_width(req_bus_width)
	) req_cdc_i (
		.clk_dst(clk_b),
		.rst_n(rst_n),
		.data_in({host_wdata, host_addr, host_we, host_req}),
		.data_out({wdata_s, addr_s, we_s, req_s})
	);

	bus_cdc #(
		.data_width(rsp_bus_width)
	) rsp_cdc_i (
		.clk_dst(clk_a),
		.rst_n(rst_a_n),
		.data_in({host_q, ack_b}),
		.data_out({host_rdata, host_ack})
	);

	// byte address to word index
	assign host_word = addr_s[9:2];

	// one access per request, ack held until req drops
	always_ff @(posedge clk_b) begin
		if (!rst_n) begin
			ack_b <= 1'b0;
			we_pulse <= 1'b0;
		end else if (req_s && !ack_b) begin
			ack_b <= 1'b1;
			we_pulse <= we_s;
		end else begin
			we_pulse <= 1'b0;
			if (!req_s) begin
				ack_b <= 1'b0;
			end
		end
	end

	// host read comes a cycle ahead of the write, so it returns the old word
	always_ff @(posedge clk_b) begin
		if (req_s && !ack_b) begin
			host_q <= mem_q[host_word];
		end
		if (we_pulse) begin
			mem_q[host_word] <= wdata_s;
		end
		rd_data <= mem_q[rd_addr];
	end

endmodule

// ==== logic/script_fetch.sv ====
`timescale 1ns/10ps

module script_fetch
	import script_pkg::*;
(
	input logic clk_b,
	input logic rst_n,
	input logic start,
	output word_addr_t rd_addr,
	input script_word_t rd_data,
	instr_if.fetch ifc
);

	word_addr_t pc_q;
	word_addr_t pc_d;
	logic issue;
	logic running_q;
	logic pend_q;
	logic valid_q;
	script_word_t instr_q;
	opcode_t held_op;
	logic consume;
	logic stop;

	assign held_op = opcode_t'(instr_q[31:28]);
	assign consume = valid_q && ifc.advance;

	// script ends once its end word is taken
	assign stop = consume && (held_op == op_end);

	always_comb begin
		pc_d = pc_q;
		issue = 1'b0;
		if (!running_q) begin
			if (start) begin
				pc_d = '0;
				issue = 1'b1;
			end
		end else if (ifc.redirect) begin
			pc_d = ifc.target;
			issue = 1'b1;
		end else if (consume && !stop) begin
			pc_d = pc_q + 1'b1;
			issue = 1'b1;
		end
	end

	// read goes out with the new pc, data is back a cycle later
	assign rd_addr = pc_d;

	always_ff @(posedge clk_b) begin
		if (!rst_n) begin
			running_q <= 1'b0;
			pend_q <= 1'b0;
			valid_q <= 1'b0;
			pc_q <= '0;
		end else begin
			pc_q <= pc_d;
			pend_q <= issue;
			if (!running_q && start) begin
				running_q <= 1'b1;
			end else if (stop) begin
				running_q <= 1'b0;
			end
			// a new issue drops whatever was in flight
			if (issue || stop) begin
				valid_q <= 1'b0;
			end else if (pend_q) begin
				valid_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_b) begin
		if (pend_q && !issue) begin
			instr_q <= rd_data;
		end
	end

	assign ifc.valid = valid_q;
	assign ifc.instr = instr_q;
	assign ifc.pc = pc_q;

endmodule

// ==== logic/delay_timer.sv ====
`timescale 1ns/10ps

module delay_timer
	import script_pkg::*;
(
	input logic clk_b,
	input logic rst_n,
	input logic load,
	input wait_count_t count,
	output logic expired
);

	wait_count_t remain_q;
	logic armed_q;

	// zero and one both expire on the cycle after load
	always_ff @(posedge clk_b) begin
		if (!rst_n) begin
			remain_q <= '0;
			armed_q <= 1'b0;
		end else if (load) begin
			armed_q <= 1'b1;
			remain_q <= (count == '0) ? '0 : count - 1'b1;
		end else if (remain_q != '0) begin
			remain_q <= remain_q - 1'b1;
		end
	end

	// sticky until the next load
	assign expired = armed_q && (remain_q == '0);

endmodule

// ==== logic/script_exec.sv ====
`timescale 1ns/10ps

module script_exec
	import script_pkg::*;
(
	input logic clk_b,
	input logic rst_n,
	input logic start,
	instr_if.exec ifc,
	output logic timer_load,
	output wait_count_t timer_count,
	input logic timer_expired,
	output logic busy,
	output logic done,
	output pin_word_t pins
);

	exec_state_t state_q;
	exec_state_t state_d;
	opcode_t op;
	logic run_valid;

	assign op = opcode_t'(ifc.instr[31:28]);
	assign run_valid = (state_q == exec_run) && ifc.valid;

	assign ifc.target = ifc.instr[7:0];
	assign timer_count = ifc.instr[23:0];
	assign busy = (state_q != exec_idle);

	always_comb begin
		state_d = state_q;
		ifc.advance = 1'b0;
		ifc.redirect = 1'b0;
		timer_load = 1'b0;
		case (state_q)
			exec_idle: begin
				if (start) begin
					state_d = exec_run;
				end
			end
			exec_run: begin
				if (ifc.valid) begin
					case (op)
						op_wait: begin
							timer_load = 1'b1;
							state_d = exec_wait;
						end
						op_jump: begin
							ifc.redirect = 1'b1;
						end
						op_end: begin
							ifc.advance = 1'b1;
							state_d = exec_idle;
						end
						// set and unknown codes
						default: begin
							ifc.advance = 1'b1;
						end
					endcase
				end
			end
			exec_wait: begin
				// wait word stays held until the timer runs out
				if (timer_expired) begin
					ifc.advance = 1'b1;
					state_d = exec_run;
				end
			end
			default: begin
				state_d = exec_idle;
			end
		endcase
	end

	always_ff @(posedge clk_b) begin
		if (!rst_n) begin
			state_q <= exec_idle;
			done <= 1'b0;
			pins <= '0;
		end else begin
			state_q <= state_d;
			done <= run_valid && (op == op_end);
			if (run_valid && (op == op_set)) begin
				pins <= ifc.instr[15:0];
			end
		end
	end

endmodule

// ==== logic/script_top.sv ====
`timescale 1ns/10ps

module script_top
	import script_pkg::*;
(
	input logic clk_a,
	input host_addr_t host_addr,
	input script_word_t host_wdata,
	input logic host_we,
	input logic host_req,
	output logic host_ack,
	output script_word_t host_rdata,
	input logic clk_b,
	input logic rst_n,
	input logic start,
	output logic busy,
	output logic done,
	output pin_word_t pins
);

	word_addr_t rd_addr;
	script_word_t rd_data;
	logic timer_load;
	wait_count_t timer_count;
	logic timer_expired;

	instr_if ifc ();

	script_mem mem_i (
		.clk_a(clk_a),
		.clk_b(clk_b),
		.rst_n(rst_n),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_we(host_we),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.host_ack(host_ack),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	script_fetch fetch_i (
		.clk_b(clk_b),
		.rst_n(rst_n),
		.start(start),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.ifc(ifc.fetch)
	);

	delay_timer timer_i (
		.clk_b(clk_b),
		.rst_n(rst_n),
		.load(timer_load),
		.count(timer_count),
		.expired(timer_expired)
	);

	script_exec exec_i (
		.clk_b(clk_b),
		.rst_n(rst_n),
		.start(start),
		.ifc(ifc.exec),
		.timer_load(timer_load),
		.timer_count(timer_count),
		.timer_expired(timer_expired),
		.busy(busy),
		.done(done),
		.pins(pins)
	);

endmodule

// ==== verification/script_tb.sv ====
`timescale 1ns/10ps

module script_tb
	import script_pkg::*;
();

	logic clk_a;
	logic clk_b;
	logic rst_n;
	logic start;
	host_addr_t host_addr;
	script_word_t host_wdata;
	script_word_t host_rdata;
	logic host_we;
	logic host_req;
	logic host_ack;
	logic busy;
	logic done;
	pin_word_t pins;

	int value_errors = 0;
	int prop_errors = 0;
	logic [31:0] lfsr_q = 32'd93531;
	int cycle_count = 0;
	int done_count = 0;
	pin_word_t last_pins = '0;
	pin_word_t pin_vals [$];
	int pin_times [$];
	pin_word_t exp_pins [$];
	int chg_base;
	int done_base;
	pin_word_t forbidden_pins = 16'hdead;
	script_word_t model [256];
	word_addr_t addrs [$];
	logic [31:0] r;
	script_word_t got;
	int wait_n;

	script_top dut_i (.*);

	always #50 clk_b = ~clk_b;
	always #35 clk_a = ~clk_a;

	// pin changes and done pulses seen at the falling edge
	always @(negedge clk_b) begin
		cycle_count++;
		if (rst_n) begin
			if (pins !== last_pins) begin
				pin_vals.push_back(pins);
				pin_times.push_back(cycle_count);
				last_pins = pins;
			end
			if (done) begin
				done_count++;
			end
		end
	end

	assert property (@(posedge clk_b) disable iff (!rst_n) done |-> !busy)
		else begin
			prop_errors++;
			$display("done pulsed while busy was still high");
		end
	assert property (@(posedge clk_b) disable iff (!rst_n) done |=> !done)
		else begin
			prop_errors++;
			$display("done stayed high for more than one cycle");
		end
	assert property (@(posedge clk_b) disable iff (!rst_n) start && !busy |=> busy)
		else begin
			prop_errors++;
			$display("busy did not rise one cycle after start");
		end
	assert property (@(posedge clk_b) disable iff (!rst_n) pins != forbidden_pins)
		else begin
			prop_errors++;
			$display("pins showed a value from a skipped set word");
		end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	function automatic script_word_t set_instr(input pin_word_t v);
		return {op_set, 12'h000, v};
	endfunction

	function automatic script_word_t wait_instr(input wait_count_t n);
		return {op_wait, 4'h0, n};
	endfunction

	function automatic script_word_t jump_instr(input word_addr_t t);
		return {op_jump, 20'h00000, t};
	endfunction

	function automatic script_word_t end_instr();
		return {op_end, 28'h0000000};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	// four-phase exchange returning the word from before any write
	task automatic host_access(input host_addr_t addr, input logic we,
			input script_word_t wdata, output script_word_t rdata);
		int cycles;
		@(negedge clk_a);
		host_addr = addr;
		host_wdata = wdata;
		host_we = we;
		@(negedge clk_a);
		host_req = 1'b1;
		cycles = 0;
		while (!host_ack && cycles < 200) begin
			@(negedge clk_a);
			cycles++;
		end
		if (!host_ack) begin
			abort_run("host_ack never rose after host_req");
		end else begin
			rdata = host_rdata;
			host_req = 1'b0;
			cycles = 0;
			while (host_ack && cycles < 200) begin
				@(negedge clk_a);
				cycles++;
			end
			if (host_ack) begin
				abort_run("host_ack stayed high after host_req fell");
			end
		end
	endtask

	task automatic host_write(input host_addr_t addr, input script_word_t w);
		script_word_t old;
		host_access(addr, 1'b1, w, old);
	endtask

	task automatic host_read(input host_addr_t addr, output script_word_t w);
		host_access(addr, 1'b0, '0, w);
	endtask

	task automatic load_word(input word_addr_t idx, input script_word_t w);
		host_write({idx, 2'b00}, w);
	endtask

	task automatic mark_bases();
		@(posedge clk_b);
		chg_base = pin_vals.size();
		done_base = done_count;
	endtask

	task automatic start_script();
		@(negedge clk_b);
		start = 1'b1;
		@(negedge clk_b);
		start = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk_b);
		while (!done && cycles < limit) begin
			@(negedge clk_b);
			cycles++;
		end
		if (!done) begin
			abort_run("script did not finish, done never pulsed");
		end else begin
			check_value("busy_after_done", 0, busy);
		end
	endtask

	task automatic finish_check(input string name);
		int n;
		@(posedge clk_b);
		n = pin_vals.size() - chg_base;
		check_value({name, "_done_count"}, 1, done_count - done_base);
		check_value({name, "_changes"}, exp_pins.size(), n);
		for (int i = 0; i < n && i < exp_pins.size(); i++) begin
			check_value(name, exp_pins[i], pin_vals[chg_base + i]);
		end
		exp_pins.delete();
	endtask

	initial begin
		clk_a = 1'b0;
		clk_b = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_we = 1'b0;
		host_req = 1'b0;

		// reset
		repeat (2) @(posedge clk_b);
		@(negedge clk_b);
		check_value("reset_busy", 0, busy);
		check_value("reset_done", 0, done);
		check_value("reset_pins", 0, pins);
		@(posedge clk_b);
		@(negedge clk_b);
		rst_n = 1'b1;
		repeat (12) @(negedge clk_a);
		check_value("reset_host_ack", 0, host_ack);
		check_value("after_reset_busy", 0, busy);
		check_value("after_reset_done", 0, done);
		check_value("after_reset_pins", 0, pins);

		// host memory
		for (int i = 0; i < 12; i++) begin
			random_bits(8, r);
			addrs.push_back(r[7:0]);
			random_bits(32, r);
			model[addrs[i]] = r;
			load_word(addrs[i], r);
		end
		foreach (addrs[i]) begin
			host_read({addrs[i], 2'b00}, got);
			check_value("host_mem", model[addrs[i]], got);
		end

		// set sequence
		load_word(8'd0, set_instr(16'h0001));
		load_word(8'd1, set_instr(16'h0012));
		load_word(8'd2, set_instr(16'h0123));
		load_word(8'd3, set_instr(16'h1234));
		load_word(8'd4, end_instr());
		exp_pins = '{16'h0001, 16'h0012, 16'h0123, 16'h1234};
		mark_bases();
		start_script();
		wait_done(200);
		finish_check("set_seq");

		// wait
		random_bits(5, r);
		wait_n = 8 + r;
		load_word(8'd0, set_instr(16'ha5a5));
		load_word(8'd1, wait_instr(wait_count_t'(wait_n)));
		load_word(8'd2, set_instr(16'h5a5a));
		load_word(8'd3, end_instr());
		exp_pins = '{16'ha5a5, 16'h5a5a};
		mark_bases();
		start_script();
		wait_done(300);
		finish_check("wait");
		if (pin_vals.size() >= chg_base + 2) begin
			assert (pin_times[chg_base + 1] - pin_times[chg_base] >= wait_n) else begin
				value_errors++;
				$display("FAIL wait_gap expected >= %0d actual %0d", wait_n,
					pin_times[chg_base + 1] - pin_times[chg_base]);
			end
		end

		// jump over a set with an unused opcode on the path
		load_word(8'd0, set_instr(16'h1111));
		load_word(8'd1, jump_instr(8'd4));
		load_word(8'd2, set_instr(16'hbad0));
		load_word(8'd3, end_instr());
		load_word(8'd4, 32'h7000_0000);
		load_word(8'd5, set_instr(16'h2222));
		load_word(8'd6, end_instr());
		forbidden_pins = 16'hbad0;
		exp_pins = '{16'h1111, 16'h2222};
		mark_bases();
		start_script();
		wait_done(200);
		finish_check("jump");
		check_value("jump_final", 16'h2222, pins);

		// start while busy and a host write during the run
		load_word(8'd0, set_instr(16'h3333));
		load_word(8'd1, set_instr(16'h3434));
		load_word(8'd2, wait_instr(24'd200));
		load_word(8'd3, set_instr(16'h4444));
		load_word(8'd4, end_instr());
		exp_pins = '{16'h3333, 16'h3434, 16'h4444};
		mark_bases();
		start_script();
		repeat (5) @(posedge clk_b);
		random_bits(32, r);
		host_write({8'd200, 2'b00}, r);
		@(negedge clk_b);
		check_value("busy_during_run", 1, busy);
		start_script();
		wait_done(600);
		repeat (20) @(posedge clk_b);
		finish_check("busy_start");
		host_read({8'd200, 2'b00}, got);
		check_value("write_while_busy", r, got);

		$display("errors: %0d value, %0d property", value_errors, prop_errors);
		if (value_errors == 0 && prop_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/script_pkg.sv
logic/bus_cdc.sv
logic/instr_if.sv
logic/script_mem.sv
logic/script_fetch.sv
logic/delay_timer.sv
logic/script_exec.sv
logic/script_top.sv
verification/script_tb.sv

// ==== Bender.yml ====
package:
  name: script_sequencer

sources:
  - logic/script_pkg.sv
  - logic/bus_cdc.sv
  - logic/instr_if.sv
  - logic/script_mem.sv
  - logic/script_fetch.sv
  - logic/delay_timer.sv
  - logic/script_exec.sv
  - logic/script_top.sv
  - target: test
    files:
      - verification/script_tb.sv
